// ==== src.f ====
gaussian_pkg.sv
gaussian_csr.sv
gaussian_line_counter.sv
gaussian_requestor.sv
gaussian.sv
gaussian_afu.sv
tb_clk_gen.sv
tb_gaussian_afu.sv

// ==== Bender.yml ====
package:
  name: gaussian_afu

sources:
  - gaussian_pkg.sv
  - gaussian_csr.sv
  - gaussian_line_counter.sv
  - gaussian_requestor.sv
  - gaussian.sv
  - gaussian_afu.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_gaussian_afu.sv

// ==== tb_gaussian_afu.sv ====
`timescale 1ns/1ps

module tb_gaussian_afu;

  import gaussian_pkg::*;

  // Lines requested over the whole run, which sizes the watchdog
  localparam int total_lines = 45;
  localparam int wd_cycles   = 200 * total_lines + 2000;

  logic               clk;
  logic               arst_n;
  logic               mmio_wr;
  logic               mmio_rd;
  csr_addr_e          mmio_addr;
  logic [63:0]        mmio_wdata;
  logic [63:0]        mmio_rdata;
  logic               mmio_rvalid;
  logic               rd_req;
  logic [addr_w-1:0]  rd_addr;
  logic               rd_rsp_valid;
  logic [line_w-1:0]  rd_rsp_data;
  logic               rd_almost_full;
  logic               wr_req;
  logic [addr_w-1:0]  wr_addr;
  logic [line_w-1:0]  wr_data;
  logic               wr_almost_full;

  integer seed      = 32'hd391;
  int     errors    = 0;
  int     checks    = 0;
  int     tests_run = 0;
  // Edge count, reads seen and reads not yet written back, all taken at the ports
  int     cyc       = 0;
  int     rd_count  = 0;
  int     port_out  = 0;
  bit     bp_en     = 1'b0;
  // Address the next read strobe of the current job should carry
  logic [addr_w-1:0] rd_expect = '0;

  // Source memory, plus the in-order response queue with the cycle each answer is due
  logic [line_w-1:0] src_mem [256];
  int                mem_due [$];
  logic [line_w-1:0] mem_data [$];
  // Cycles of read responses still waiting for their write
  int                rsp_cyc [$];
  // Writes of the current job
  logic [addr_w-1:0] wr_addr_log [$];
  logic [line_w-1:0] wr_data_log [$];

  tb_clk_gen u_clk_gen (
    .clk (clk)
  );

  gaussian_afu u_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .mmio_wr        (mmio_wr),
    .mmio_rd        (mmio_rd),
    .mmio_addr      (mmio_addr),
    .mmio_wdata     (mmio_wdata),
    .mmio_rdata     (mmio_rdata),
    .mmio_rvalid    (mmio_rvalid),
    .rd_req         (rd_req),
    .rd_addr        (rd_addr),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .rd_almost_full (rd_almost_full),
    .wr_req         (wr_req),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .wr_almost_full (wr_almost_full)
  );

  function automatic void check_eq(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endfunction

  // Kernel 1 4 6 4 1 with edge clamping, rounded by 8 and divided by 16
  function automatic logic [63:0] ref_filter(input logic [63:0] line);
    int          w [5] = '{1, 4, 6, 4, 1};
    int          acc;
    int          j;
    logic [63:0] res;
    res = '0;
    for (int p = 0; p < 8; p++) begin
      acc = 8;
      for (int k = -2; k <= 2; k++) begin
        j = p + k;
        if (j < 0) j = 0;
        if (j > 7) j = 7;
        acc += w[k + 2] * int'(line[j*8 +: 8]);
      end
      res[p*8 +: 8] = 8'(acc / 16);
    end
    return res;
  endfunction

  // Memory model and port monitor share one block so the cycle count has a single owner
  always @(posedge clk) begin : port_model
    int lat;
    cyc++;
    if (wr_req) begin
      wr_addr_log.push_back(wr_addr);
      wr_data_log.push_back(wr_data);
      port_out--;
      assert (rsp_cyc.size() > 0) else begin
        $display("write strobe seen without a read response before it");
        errors++;
      end
      if (rsp_cyc.size() > 0) begin
        check_eq("wr_req delay", 64'(cyc - rsp_cyc[0]), 64'd2);
        void'(rsp_cyc.pop_front());
      end
    end
    if (rd_rsp_valid) begin
      rsp_cyc.push_back(cyc);
    end
    if (rd_req) begin
      assert (!(rd_almost_full || wr_almost_full)) else begin
        $display("read strobe issued while an almost-full level was high");
        errors++;
      end
      // Reads walk the source lines one by one from the base
      check_eq("rd_addr", 64'(rd_addr), 64'(rd_expect));
      rd_expect++;
      // Latency of 1 to 6 cycles, answers still leave in request order
      lat = 1 + ({$random(seed)} % 6);
      mem_due.push_back(cyc + lat - 1);
      mem_data.push_back(src_mem[rd_addr[7:0]]);
      rd_count++;
      port_out++;
    end
    assert (port_out <= max_outstanding) else begin
      $display("reads in flight at the ports went past the limit, %0d", port_out);
      errors++;
    end
    #1;
    if (mem_due.size() > 0 && mem_due[0] <= cyc) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_data  = mem_data.pop_front();
      void'(mem_due.pop_front());
    end else begin
      rd_rsp_valid = 1'b0;
    end
  end

  // Random almost-full levels, only while a back-pressure test runs
  always @(posedge clk) begin : bp_drive
    bit en;
    // The enable is taken at the edge, away from the point where tests change it
    en = bp_en;
    #1;
    if (en) begin
      rd_almost_full = ({$random(seed)} % 3) == 0;
      wr_almost_full = ({$random(seed)} % 3) == 0;
    end else begin
      rd_almost_full = 1'b0;
      wr_almost_full = 1'b0;
    end
  end

  // Tasks start and end 1 ns after a rising edge
  task automatic mmio_write(input csr_addr_e addr, input logic [63:0] data);
    mmio_wr    = 1'b1;
    mmio_addr  = addr;
    mmio_wdata = data;
    @(posedge clk);
    #1;
    mmio_wr = 1'b0;
  endtask

  task automatic mmio_read(input csr_addr_e addr, output logic [63:0] data);
    mmio_rd   = 1'b1;
    mmio_addr = addr;
    @(posedge clk);
    #1;
    mmio_rd = 1'b0;
    checks++;
    assert (mmio_rvalid === 1'b1) else begin
      $display("no read valid one cycle after the read strobe");
      errors++;
    end
    data = mmio_rdata;
  endtask

  task automatic run_job(input logic [31:0] src, input logic [31:0] dst, input int n,
                         input bit poke_start);
    logic [63:0] st;
    int          polls;
    int          rd_before;
    wr_addr_log.delete();
    wr_data_log.delete();
    rd_before = rd_count;
    rd_expect = src;
    mmio_write(csr_src, 64'(src));
    mmio_write(csr_dst, 64'(dst));
    mmio_write(csr_num_lines, 64'(n));
    mmio_write(csr_ctrl, 64'd1);
    mmio_read(csr_status, st);
    if (n > 0) check_eq("status.busy", 64'(st[0]), 64'd1);
    // A second start once the first read is out must leave the running job alone
    if (poke_start) mmio_write(csr_ctrl, 64'd1);
    polls = 0;
    do begin
      mmio_read(csr_status, st);
      polls++;
    end while (!st[1] && polls < 200 * n + 200);
    checks++;
    assert (st[1]) else begin
      $display("done never set for a job of %0d lines", n);
      errors++;
    end
    check_eq("status.busy", 64'(st[0]), 64'd0);
    check_eq("status.lines_written", 64'(st[31:16]), 64'(n));
    check_eq("rd_req count", 64'(rd_count - rd_before), 64'(n));
    check_eq("wr_req count", 64'(wr_addr_log.size()), 64'(n));
    for (int i = 0; i < wr_addr_log.size(); i++) begin
      check_eq("wr_addr", 64'(wr_addr_log[i]), 64'(dst + i));
      check_eq("wr_data", wr_data_log[i], ref_filter(src_mem[8'(src + i)]));
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  // Reset state, then register readback
  task automatic register_access();
    int          e0;
    logic [63:0] rd;
    e0 = errors;
    check_eq("rd_req", 64'(rd_req), 64'd0);
    check_eq("wr_req", 64'(wr_req), 64'd0);
    check_eq("mmio_rvalid", 64'(mmio_rvalid), 64'd0);
    mmio_read(csr_status, rd);
    check_eq("status", rd, 64'd0);
    mmio_write(csr_src, 64'h8765_4320);
    mmio_write(csr_dst, 64'h1357_9bd0);
    mmio_write(csr_num_lines, 64'h0abc);
    mmio_read(csr_src, rd);
    check_eq("src_base", rd, 64'h8765_4320);
    mmio_read(csr_dst, rd);
    check_eq("dst_base", rd, 64'h1357_9bd0);
    mmio_read(csr_num_lines, rd);
    check_eq("num_lines", rd, 64'h0abc);
    report_test("register access", e0);
  endtask

  // An edge impulse and a flat line both lean on the clamping
  task automatic impulse_and_constant();
    int e0;
    e0 = errors;
    src_mem[200] = 64'h0000_0000_0000_00ff;
    src_mem[201] = 64'h5a5a_5a5a_5a5a_5a5a;
    run_job(32'd200, 32'h300, 1, 1'b0);
    run_job(32'd201, 32'h310, 1, 1'b0);
    report_test("impulse and constant", e0);
  endtask

  task automatic random_latency_job();
    int e0;
    e0 = errors;
    run_job(32'd16, 32'h100, 16, 1'b0);
    report_test("16 lines random latency", e0);
  endtask

  task automatic back_pressure_job();
    int e0;
    e0 = errors;
    bp_en = 1'b1;
    run_job(32'd64, 32'h400, 24, 1'b0);
    bp_en = 1'b0;
    report_test("24 lines back-pressure", e0);
  endtask

  // Empty job first, then a short one with a stray start
  task automatic empty_job_and_restart();
    int e0;
    e0 = errors;
    run_job(32'd128, 32'h500, 0, 1'b0);
    run_job(32'd128, 32'h600, 3, 1'b1);
    report_test("empty job and restart", e0);
  endtask

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", wd_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    mmio_wr        = 1'b0;
    mmio_rd        = 1'b0;
    mmio_addr      = csr_ctrl;
    mmio_wdata     = '0;
    rd_rsp_valid   = 1'b0;
    rd_rsp_data    = '0;
    rd_almost_full = 1'b0;
    wr_almost_full = 1'b0;
    for (int a = 0; a < 256; a++) begin
      src_mem[a] = {$random(seed), $random(seed)};
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    register_access();
    impulse_and_constant();
    random_latency_job();
    back_pressure_job();
    empty_job_and_restart();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_gaussian_afu

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  // Full clock period in ns
  localparam int period_ns = 8;

  // Free running clock that starts low
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule : tb_clk_gen

// ==== gaussian_afu.sv ====
`timescale 1ns/1ps

module gaussian_afu (
  input  logic                              clk,
  input  logic                              arst_n,
  // Register port
  input  logic                              mmio_wr,
  input  logic                              mmio_rd,
  input  gaussian_pkg::csr_addr_e           mmio_addr,
  input  logic [63:0]                       mmio_wdata,
  output logic [63:0]                       mmio_rdata,
  output logic                              mmio_rvalid,
  // Read port
  output logic                              rd_req,
  output logic [gaussian_pkg::addr_w-1:0]   rd_addr,
  input  logic                              rd_rsp_valid,
  input  logic [gaussian_pkg::line_w-1:0]   rd_rsp_data,
  input  logic                              rd_almost_full,
  // Write port
  output logic                              wr_req,
  output logic [gaussian_pkg::addr_w-1:0]   wr_addr,
  output logic [gaussian_pkg::line_w-1:0]   wr_data,
  input  logic                              wr_almost_full
);

  import gaussian_pkg::*;

  // Job setup from the register block
  logic               start;
  logic [addr_w-1:0]  src_base;
  logic [addr_w-1:0]  dst_base;
  logic [count_w-1:0] num_lines;

  // Status back to the register block
  logic               busy;
  logic               done;
  logic [count_w-1:0] lines_written;

  // Requestor and counter handshake
  logic               issue_rd;
  logic               wr_fire;
  logic [addr_w-1:0]  rd_index_addr;
  logic [addr_w-1:0]  wr_index_addr;
  logic               can_issue;
  logic               all_requested;
  logic               all_written;

  // Filter path
  logic               filt_valid_in;
  logic [line_w-1:0]  filt_data_in;
  logic               filt_valid;
  logic [line_w-1:0]  filt_data;

  gaussian_csr uu_gaussian_csr (
    .clk           (clk),
    .arst_n        (arst_n),
    .mmio_wr       (mmio_wr),
    .mmio_rd       (mmio_rd),
    .mmio_addr     (mmio_addr),
    .mmio_wdata    (mmio_wdata),
    .busy          (busy),
    .done          (done),
    .lines_written (lines_written),
    .mmio_rdata    (mmio_rdata),
    .mmio_rvalid   (mmio_rvalid),
    .start         (start),
    .src_base      (src_base),
    .dst_base      (dst_base),
    .num_lines     (num_lines)
  );

  gaussian_line_counter uu_gaussian_line_counter (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (start),
    .src_base      (src_base),
    .dst_base      (dst_base),
    .num_lines     (num_lines),
    .issue_rd      (issue_rd),
    .wr_fire       (wr_fire),
    .rd_index_addr (rd_index_addr),
    .wr_index_addr (wr_index_addr),
    .can_issue     (can_issue),
    .all_requested (all_requested),
    .all_written   (all_written),
    .lines_written (lines_written)
  );

  gaussian_requestor uu_gaussian_requestor (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .can_issue      (can_issue),
    .all_requested  (all_requested),
    .all_written    (all_written),
    .rd_index_addr  (rd_index_addr),
    .wr_index_addr  (wr_index_addr),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .filt_valid     (filt_valid),
    .filt_data      (filt_data),
    .issue_rd       (issue_rd),
    .wr_fire        (wr_fire),
    .rd_req         (rd_req),
    .rd_addr        (rd_addr),
    .filt_valid_in  (filt_valid_in),
    .filt_data_in   (filt_data_in),
    .wr_req         (wr_req),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .busy           (busy),
    .done           (done)
  );

  gaussian uu_gaussian (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (filt_valid_in),
    .data_in   (filt_data_in),
    .valid_out (filt_valid),
    .data_out  (filt_data)
  );

endmodule : gaussian_afu

// ==== gaussian.sv ====
`timescale 1ns/1ps

module gaussian (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             valid_in,
  input  logic [gaussian_pkg::line_w-1:0]  data_in,
  output logic                             valid_out,
  output logic [gaussian_pkg::line_w-1:0]  data_out
);

  import gaussian_pkg::*;

  // Weighted sums formed from the incoming line
  logic [sum_w-1:0] sum_d [pix_per_line];
  // Stage 1 registers
  logic [sum_w-1:0] sum_q [pix_per_line];
  logic             valid_q;

  // Fetches one pixel widened to sum width
  // Indices past either end are pinned to the edge pixel
  function automatic logic [sum_w-1:0] pix_at(input logic [line_w-1:0] line, input int idx);
    int k;
    if (idx < 0) begin
      k = 0;
    end else if (idx > pix_per_line - 1) begin
      k = pix_per_line - 1;
    end else begin
      k = idx;
    end
    return sum_w'(line[k*pix_w +: pix_w]);
  endfunction

  // Stage 1 datapath applying the 1 4 6 4 1 kernel to every pixel of the line
  // The largest sum is 16 times 255 so nothing overflows sum_w
  always_comb begin
    for (int i = 0; i < pix_per_line; i++) begin
      sum_d[i] = pix_at(data_in, i - 2)
               + (pix_at(data_in, i - 1) << 2)
               + (pix_at(data_in, i) << 2) + (pix_at(data_in, i) << 1)
               + (pix_at(data_in, i + 1) << 2)
               + pix_at(data_in, i + 2);
    end
  end

  // Valid bits are control and come out of reset low
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_q   <= valid_in;
      valid_out <= valid_q;
    end
  end

  // Stage 1 register
  always_ff @(posedge clk) begin
    for (int i = 0; i < pix_per_line; i++) begin
      sum_q[i] <= sum_d[i];
    end
  end

  // Stage 2 rounds to nearest and divides by the kernel weight of 16
  // The rounded sum stays below 4096 so the top pix_w bits hold the result
  always_ff @(posedge clk) begin
    for (int i = 0; i < pix_per_line; i++) begin
      data_out[i*pix_w +: pix_w] <= pix_w'((sum_q[i] + sum_w'(kern_round)) >> kern_shift);
    end
  end

endmodule : gaussian

// ==== gaussian_requestor.sv ====
`timescale 1ns/1ps

module gaussian_requestor (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              start,
  input  logic                              can_issue,
  input  logic                              all_requested,
  input  logic                              all_written,
  input  logic [gaussian_pkg::addr_w-1:0]   rd_index_addr,
  input  logic [gaussian_pkg::addr_w-1:0]   wr_index_addr,
  input  logic                              rd_almost_full,
  input  logic                              wr_almost_full,
  input  logic                              rd_rsp_valid,
  input  logic [gaussian_pkg::line_w-1:0]   rd_rsp_data,
  input  logic                              filt_valid,
  input  logic [gaussian_pkg::line_w-1:0]   filt_data,
  output logic                              issue_rd,
  output logic                              wr_fire,
  output logic                              rd_req,
  output logic [gaussian_pkg::addr_w-1:0]   rd_addr,
  output logic                              filt_valid_in,
  output logic [gaussian_pkg::line_w-1:0]   filt_data_in,
  output logic                              wr_req,
  output logic [gaussian_pkg::addr_w-1:0]   wr_addr,
  output logic [gaussian_pkg::line_w-1:0]   wr_data,
  output logic                              busy,
  output logic                              done
);

  import gaussian_pkg::*;

  req_state_e state_q;
  req_state_e state_d;

  // High in a cycle where a read strobe goes out
  logic read_ok;

  // State register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      // A new job may start from reset or after a finished one
      st_idle,
      st_done: begin
        if (start) begin
          state_d = st_run;
        end
      end
      // An empty job passes straight to done without any request
      st_run: begin
        if (all_requested && all_written) begin
          state_d = st_done;
        end else if (all_requested) begin
          state_d = st_drain;
        end
      end
      // Waits for the last filtered line to leave on the write port
      st_drain: begin
        if (all_written) begin
          state_d = st_done;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  // Either almost-full level holds back new reads
  // The counter already limits the window and the remaining line count
  assign read_ok = (state_q == st_run) && can_issue && !rd_almost_full && !wr_almost_full;

  assign rd_req   = read_ok;
  assign issue_rd = read_ok;
  assign rd_addr  = rd_index_addr;

  // Responses arrive in request order and go to the filter untouched
  assign filt_valid_in = rd_rsp_valid;
  assign filt_data_in  = rd_rsp_data;

  // Filtered lines are written as soon as they appear, never throttled
  // The write address follows the written count so results land in order
  assign wr_req  = filt_valid;
  assign wr_data = filt_data;
  assign wr_addr = wr_index_addr;
  assign wr_fire = filt_valid;

  // Status levels for the register block
  assign busy = (state_q == st_run) || (state_q == st_drain);
  assign done = (state_q == st_done);

  // Every response comes out of the filter as a write two cycles later
  a_rsp_to_write : assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_rsp_valid |-> ##2 wr_req
  );

endmodule : gaussian_requestor

// ==== gaussian_line_counter.sv ====
`timescale 1ns/1ps

module gaussian_line_counter (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              start,
  input  logic [gaussian_pkg::addr_w-1:0]   src_base,
  input  logic [gaussian_pkg::addr_w-1:0]   dst_base,
  input  logic [gaussian_pkg::count_w-1:0]  num_lines,
  input  logic                              issue_rd,
  input  logic                              wr_fire,
  output logic [gaussian_pkg::addr_w-1:0]   rd_index_addr,
  output logic [gaussian_pkg::addr_w-1:0]   wr_index_addr,
  output logic                              can_issue,
  output logic                              all_requested,
  output logic                              all_written,
  output logic [gaussian_pkg::count_w-1:0]  lines_written
);

  import gaussian_pkg::*;

  logic [count_w-1:0] req_cnt;
  logic [count_w-1:0] wr_cnt;
  logic [count_w-1:0] req_nxt;
  logic [count_w-1:0] wr_nxt;
  logic [count_w-1:0] outstanding;

  // Counts as they will be after this cycle's strobes
  assign req_nxt = req_cnt + count_w'(issue_rd);
  assign wr_nxt  = wr_cnt + count_w'(wr_fire);

  // Memory answers in order, so reads in flight are simply requested minus written
  assign outstanding = req_cnt - wr_cnt;

  // Both addresses walk forward one line per transfer
  assign rd_index_addr = src_base + addr_w'(req_cnt);
  assign wr_index_addr = dst_base + addr_w'(wr_cnt);

  assign all_requested = (req_cnt == num_lines);
  // Looks ahead through wr_fire so the job can close the cycle after its last write
  assign all_written   = (wr_nxt == num_lines);
  assign lines_written = wr_cnt;

  // Can_issue is registered from the next-state counts so it is never stale
  // It stays low for the cycle after start while the counts settle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_cnt   <= '0;
      wr_cnt    <= '0;
      can_issue <= 1'b0;
    end else if (start) begin
      req_cnt   <= '0;
      wr_cnt    <= '0;
      can_issue <= 1'b0;
    end else begin
      req_cnt   <= req_nxt;
      wr_cnt    <= wr_nxt;
      can_issue <= (req_nxt < num_lines) && ((req_nxt - wr_nxt) < count_w'(max_outstanding));
    end
  end

  // The read window seen by memory never grows past its limit
  a_outstanding_limit : assert property (
    @(posedge clk) disable iff (!arst_n)
    outstanding <= count_w'(max_outstanding)
  );

endmodule : gaussian_line_counter

// ==== gaussian_csr.sv ====
`timescale 1ns/1ps

module gaussian_csr (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              mmio_wr,
  input  logic                              mmio_rd,
  input  gaussian_pkg::csr_addr_e           mmio_addr,
  input  logic [63:0]                       mmio_wdata,
  input  logic                              busy,
  input  logic                              done,
  input  logic [gaussian_pkg::count_w-1:0]  lines_written,
  output logic [63:0]                       mmio_rdata,
  output logic                              mmio_rvalid,
  output logic                              start,
  output logic [gaussian_pkg::addr_w-1:0]   src_base,
  output logic [gaussian_pkg::addr_w-1:0]   dst_base,
  output logic [gaussian_pkg::count_w-1:0]  num_lines
);

  import gaussian_pkg::*;

  // Read data selected in the cycle of the read strobe
  logic [63:0] rd_mux;

  // Writing bit 0 of the control register launches a job
  // A write while a job is running is ignored so the job registers stay coherent
  // Start is decoded straight from the write strobe so the requestor
  // leaves idle at the same edge that the write lands
  assign start = mmio_wr && (mmio_addr == csr_ctrl) && mmio_wdata[0] && !busy;

  // Job registers
  // Software is expected to program them while the block is idle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_base  <= '0;
      dst_base  <= '0;
      num_lines <= '0;
    end else if (mmio_wr) begin
      case (mmio_addr)
        csr_src:       src_base  <= mmio_wdata[addr_w-1:0];
        csr_dst:       dst_base  <= mmio_wdata[addr_w-1:0];
        csr_num_lines: num_lines <= mmio_wdata[count_w-1:0];
        default:       ;
      endcase
    end
  end

  // Read mux
  // The control register is write only and reads back as zero like any unknown offset
  always_comb begin
    rd_mux = '0;
    case (mmio_addr)
      csr_src:       rd_mux[addr_w-1:0]  = src_base;
      csr_dst:       rd_mux[addr_w-1:0]  = dst_base;
      csr_num_lines: rd_mux[count_w-1:0] = num_lines;
      // Status holds busy in bit 0, done in bit 1 and the written count in 31:16
      csr_status:    rd_mux = {32'b0, lines_written, 14'b0, done, busy};
      default:       rd_mux = '0;
    endcase
  end

  // The valid strobe follows the read strobe by exactly one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mmio_rvalid <= 1'b0;
    end else begin
      mmio_rvalid <= mmio_rd;
    end
  end

  // Read data is only meaningful alongside mmio_rvalid
  always_ff @(posedge clk) begin
    if (mmio_rd) begin
      mmio_rdata <= rd_mux;
    end
  end

  // The requestor must report busy right after it accepts a start
  a_busy_after_start : assert property (
    @(posedge clk) disable iff (!arst_n)
    start |=> (busy || done)
  );

endmodule : gaussian_csr

// ==== gaussian_pkg.sv ====
package gaussian_pkg;

  // Pixel and line geometry of the filter datapath
  localparam int pix_w        = 8;
  localparam int pix_per_line = 8;
  localparam int line_w       = pix_w * pix_per_line;

  // Line addresses count whole 64-bit lines and not bytes
  localparam int addr_w  = 32;
  localparam int count_w = 16;

  // Limit on reads in flight toward memory
  localparam int max_outstanding = 8;

  // The 1 4 6 4 1 kernel sums to 16, so the result is rounded by 8 and shifted by 4
  localparam int kern_shift = 4;
  localparam int kern_round = 8;

  // A weighted sum needs four more bits than a pixel
  localparam int sum_w = pix_w + kern_shift;

  // Register offsets seen on the register port
  typedef enum logic [3:0] {
    csr_ctrl      = 4'd0,
    csr_src       = 4'd1,
    csr_dst       = 4'd2,
    csr_num_lines = 4'd3,
    csr_status    = 4'd4
  } csr_addr_e;

  // Job states of the requestor
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain,
    st_done
  } req_state_e;

endpackage : gaussian_pkg
